// File: hw/wallace_pkg.sv
package wallace_pkg;

  // operand and result widths
  localparam int OPERAND_W = 24;
  localparam int PRODUCT_W = 2 * OPERAND_W;
  localparam int LO_W      = 8;
  localparam int HI_W      = PRODUCT_W - LO_W;

  // row bookkeeping for the tree
  localparam int PP_ROWS        = OPERAND_W;
  localparam int MID_ROWS       = 6;  // 24 -> 16 -> 11 -> 8 -> 6
  localparam int STAGE_A_LEVELS = 4;
  localparam int STAGE_B_LEVELS = 3;  // 6 -> 4 -> 3 -> 2

  typedef logic [OPERAND_W-1:0] operand_t;
  typedef logic [PRODUCT_W-1:0] product_t;  // one weighted row
  typedef logic [HI_W-1:0]      hi_t;
  typedef logic [LO_W-1:0]      lo_t;

  // each group of three rows gives two, leftovers pass
  function automatic int rows_after_layer(input int rows);
    int groups;
    int left;
    groups = rows / 3;
    left   = rows % 3;
    return 2 * groups + left;
  endfunction

  // row count after a chain of layers
  function automatic int rows_after_levels(input int rows, input int levels);
    int n;
    n = rows;
    for (int l = 0; l < levels; l++) begin
      n = rows_after_layer(n);
    end
    return n;
  endfunction

endpackage

// File: hw/csa_layer.sv
`timescale 1ns/1ns

module csa_layer #(
  parameter int IN_ROWS = wallace_pkg::PP_ROWS
) (
  input  wallace_pkg::product_t rows_in  [IN_ROWS],
  output wallace_pkg::product_t rows_out [wallace_pkg::rows_after_layer(IN_ROWS)]
);

  import wallace_pkg::*;

  localparam int GROUPS   = IN_ROWS / 3;
  localparam int LEFTOVER = IN_ROWS % 3;

  genvar g;
  genvar k;

  // full adders across all columns of a group at once
  generate
    for (g = 0; g < GROUPS; g++) begin : grp
      product_t r0;
      product_t r1;
      product_t r2;
      product_t maj;

      assign r0 = rows_in[3*g];
      assign r1 = rows_in[3*g+1];
      assign r2 = rows_in[3*g+2];

      assign maj = (r0 & r1) | (r0 & r2) | (r1 & r2);

      assign rows_out[2*g]   = r0 ^ r1 ^ r2;  // sum row
      assign rows_out[2*g+1] = maj << 1;      // carry row, msb carry lost
    end

    // rows that do not fill a group
    for (k = 0; k < LEFTOVER; k++) begin : pass
      assign rows_out[2*GROUPS+k] = rows_in[3*GROUPS+k];
    end
  endgenerate

endmodule

// File: hw/partial_product_stage.sv
`timescale 1ns/1ns

module partial_product_stage (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid,
  input  wallace_pkg::operand_t a,
  input  wallace_pkg::operand_t b,
  output wallace_pkg::product_t pp_rows [wallace_pkg::PP_ROWS],
  output logic                pp_valid
);

  import wallace_pkg::*;

  operand_t a_q;
  operand_t b_q;
  logic     valid_q;

  // operand capture, no reset on payload
  always_ff @(posedge clk) begin
    a_q <= a;
    b_q <= b;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= in_valid;
    end
  end

  // and array from registered operands
  always_comb begin
    for (int i = 0; i < PP_ROWS; i++) begin
      pp_rows[i] = product_t'(a_q & {OPERAND_W{b_q[i]}}) << i;  // row weight 2^i
    end
  end

  assign pp_valid = valid_q;

endmodule

// File: hw/reduction_stage.sv
`timescale 1ns/1ns

module reduction_stage #(
  parameter int IN_ROWS = wallace_pkg::PP_ROWS,
  parameter int LEVELS  = wallace_pkg::STAGE_A_LEVELS
) (
  input  logic                  clk,
  input  logic                  rst,
  input  wallace_pkg::product_t rows_in  [IN_ROWS],
  input  logic                  in_valid,
  output wallace_pkg::product_t rows_out [wallace_pkg::rows_after_levels(IN_ROWS, LEVELS)],
  output logic                  out_valid
);

  import wallace_pkg::*;

  localparam int OUT_ROWS = rows_after_levels(IN_ROWS, LEVELS);

  genvar l;

  // each level takes its row count from the one before
  generate
    for (l = 0; l < LEVELS; l++) begin : level
      localparam int N_IN  = rows_after_levels(IN_ROWS, l);
      localparam int N_OUT = rows_after_layer(N_IN);

      product_t lvl_out [N_OUT];

      if (l == 0) begin : first
        csa_layer #(
          .IN_ROWS (N_IN)
        ) u_layer (
          .rows_in  (rows_in),
          .rows_out (lvl_out)
        );
      end else begin : next
        csa_layer #(
          .IN_ROWS (N_IN)
        ) u_layer (
          .rows_in  (level[l-1].lvl_out),
          .rows_out (lvl_out)
        );
      end
    end
  endgenerate

  product_t rows_q [OUT_ROWS];
  logic     valid_q;

  always_ff @(posedge clk) begin
    rows_q <= level[LEVELS-1].lvl_out;  // pipeline cut
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= in_valid;
    end
  end

  assign rows_out  = rows_q;
  assign out_valid = valid_q;

endmodule

// File: hw/low_byte_resolver.sv
`timescale 1ns/1ns

module low_byte_resolver (
  input  logic                  clk,
  input  logic                  rst,
  input  wallace_pkg::product_t rows_in [2],
  input  logic                  in_valid,
  output wallace_pkg::hi_t      x,
  output wallace_pkg::hi_t      y,
  output wallace_pkg::lo_t      z,
  output logic                  out_valid
);

  import wallace_pkg::*;

  logic [LO_W:0] lo_sum;  // extra bit is the carry into bit 8
  hi_t           h0;
  hi_t           h1;
  hi_t           h2;
  hi_t           x_next;
  hi_t           y_next;

  assign lo_sum = {1'b0, rows_in[0][LO_W-1:0]} + {1'b0, rows_in[1][LO_W-1:0]};

  assign h0 = rows_in[0][PRODUCT_W-1:LO_W];
  assign h1 = rows_in[1][PRODUCT_W-1:LO_W];
  assign h2 = hi_t'(lo_sum[LO_W]);

  // last 3:2 step folds the low carry in
  assign x_next = h0 ^ h1 ^ h2;
  assign y_next = ((h0 & h1) | (h0 & h2) | (h1 & h2)) << 1;  // bit 47 carry dropped

  always_ff @(posedge clk) begin
    x <= x_next;
    y <= y_next;
    z <= lo_sum[LO_W-1:0];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

endmodule

// File: hw/wallace_mult_24x24.sv
`timescale 1ns/1ns

module wallace_mult_24x24 (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  input  wallace_pkg::operand_t a,
  input  wallace_pkg::operand_t b,
  output logic                  out_valid,
  output wallace_pkg::hi_t      x,  // sum high
  output wallace_pkg::hi_t      y,  // carry high
  output wallace_pkg::lo_t      z   // resolved low byte
);

  import wallace_pkg::*;

  product_t pp_rows   [PP_ROWS];
  logic     pp_valid;
  product_t mid_rows  [MID_ROWS];
  logic     mid_valid;
  product_t last_rows [2];
  logic     last_valid;

  // cycle 1, and array
  partial_product_stage pp_stage (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .a        (a),
    .b        (b),
    .pp_rows  (pp_rows),
    .pp_valid (pp_valid)
  );

  // cycle 2, 24 rows down to 6
  reduction_stage #(
    .IN_ROWS (PP_ROWS),
    .LEVELS  (STAGE_A_LEVELS)
  ) stage_a (
    .clk       (clk),
    .rst       (rst),
    .rows_in   (pp_rows),
    .in_valid  (pp_valid),
    .rows_out  (mid_rows),
    .out_valid (mid_valid)
  );

  // cycle 3, 6 rows down to 2
  reduction_stage #(
    .IN_ROWS (MID_ROWS),
    .LEVELS  (STAGE_B_LEVELS)
  ) stage_b (
    .clk       (clk),
    .rst       (rst),
    .rows_in   (mid_rows),
    .in_valid  (mid_valid),
    .rows_out  (last_rows),
    .out_valid (last_valid)
  );

  // cycle 4
  low_byte_resolver resolver (
    .clk       (clk),
    .rst       (rst),
    .rows_in   (last_rows),
    .in_valid  (last_valid),
    .x         (x),
    .y         (y),
    .z         (z),
    .out_valid (out_valid)
  );

endmodule

// File: verification/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // reset released just after an edge
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst = 1'b0;
  end

endmodule

// File: verification/tb_wallace_mult_24x24.sv
`timescale 1ns/1ns

module tb_wallace_mult_24x24;

  import wallace_pkg::*;

  localparam int CLK_PERIOD    = 40;
  localparam int RESET_CYCLES  = 4;
  localparam int LATENCY       = 4;
  localparam int DRIVE_DELAY   = 2;
  localparam int CORNER_N      = 56;
  localparam int STREAM_N      = 200;
  localparam int BUBBLE_N      = 300;
  localparam int TOTAL_VECTORS = CORNER_N + STREAM_N + BUBBLE_N;
  localparam int WATCHDOG_NS   = (TOTAL_VECTORS + 50) * CLK_PERIOD;

  logic     clk;
  logic     rst;
  logic     in_valid;
  operand_t a;
  operand_t b;
  logic     out_valid;
  hi_t      x;
  hi_t      y;
  lo_t      z;

  product_t           exp_q [$];
  string              name_q [$];
  product_t           head_prod;
  string              head_name;
  int                 pending;
  logic [LATENCY-1:0] valid_hist;  // in_valid as sampled at each edge
  product_t           got_prod;
  string              cur_test;
  integer             seed;
  int                 value_errors;
  int                 protocol_errors;

  tb_clock #(
    .PERIOD_NS    (CLK_PERIOD),
    .RESET_CYCLES (RESET_CYCLES)
  ) clock_gen (
    .clk (clk),
    .rst (rst)
  );

  wallace_mult_24x24 DUT (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .a         (a),
    .b         (b),
    .out_valid (out_valid),
    .x         (x),
    .y         (y),
    .z         (z)
  );

  // redundant high part resolved here
  assign got_prod = ((product_t'(x) + product_t'(y)) << LO_W) + product_t'(z);

  // scoreboard updates on the rising edge only
  always @(posedge clk) begin
    if (out_valid && exp_q.size() > 0) begin
      void'(exp_q.pop_front());
      void'(name_q.pop_front());
    end
    if (in_valid && !rst) begin
      exp_q.push_back(product_t'(a) * product_t'(b));
      name_q.push_back(cur_test);
    end
    valid_hist = {valid_hist[LATENCY-2:0], in_valid & ~rst};
    if (exp_q.size() > 0) begin
      head_prod = exp_q[0];
      head_name = name_q[0];
    end else begin
      head_prod = '0;
      head_name = "none";
    end
    pending = exp_q.size();
  end

  // checks sample on the falling edge away from dut updates
  reset_check: assert property (@(negedge clk) rst |-> !out_valid)
    else begin
      protocol_errors = protocol_errors + 1;
      $display("out_valid went high while reset was asserted");
    end

  valid_delay_check: assert property (@(negedge clk) out_valid == valid_hist[LATENCY-1])
    else begin
      protocol_errors = protocol_errors + 1;
      $display("[ERROR] %s valid delay: expected %b, got %b",
               cur_test, valid_hist[LATENCY-1], out_valid);
    end

  empty_check: assert property (@(negedge clk) out_valid |-> pending > 0)
    else begin
      protocol_errors = protocol_errors + 1;
      $display("out_valid high with no product pending in test %s", cur_test);
    end

  product_check: assert property (@(negedge clk) out_valid |-> got_prod == head_prod)
    else begin
      value_errors = value_errors + 1;
      $display("[ERROR] %s product: expected %h, got %h", head_name, head_prod, got_prod);
    end

  low_byte_check: assert property (@(negedge clk) out_valid |-> z == lo_t'(head_prod))
    else begin
      value_errors = value_errors + 1;
      $display("[ERROR] %s low byte: expected %h, got %h", head_name, lo_t'(head_prod), z);
    end

  task automatic drive(input logic v, input operand_t av, input operand_t bv);
    @(posedge clk);
    #DRIVE_DELAY;
    in_valid = v;
    a        = av;
    b        = bv;
  endtask

  task automatic send(input operand_t av, input operand_t bv);
    drive(1'b1, av, bv);
  endtask

  // stop driving, then wait for the pipeline to empty
  task automatic wait_results(input int limit);
    int n;
    n = 0;
    drive(1'b0, '0, '0);
    while (pending != 0 && n < limit) begin
      @(posedge clk);
      #DRIVE_DELAY;
      n++;
    end
    if (pending != 0) begin
      protocol_errors = protocol_errors + 1;
      $display("%0d products never came out in test %s", pending, cur_test);
    end
  endtask

  task automatic corner_products();
    operand_t r;
    cur_test = "corners";
    r = operand_t'($random(seed));
    send('0, r);
    send(r, '0);
    send('0, '1);
    send(operand_t'(1), r);
    send(operand_t'(1), '1);
    send(operand_t'(1), '0);
    send(r, operand_t'(1));
    send('1, '1);
    for (int i = 0; i < OPERAND_W; i++) begin
      send(operand_t'(1) << i, operand_t'(1) << (OPERAND_W - 1 - i));
      send(operand_t'(1) << i, operand_t'(1) << i);
    end
    wait_results(LATENCY + 4);
  endtask

  task automatic random_stream();
    integer r1;
    integer r2;
    cur_test = "stream";
    for (int i = 0; i < STREAM_N; i++) begin
      r1 = $random(seed);
      r2 = $random(seed);
      send(r1[OPERAND_W-1:0], r2[OPERAND_W-1:0]);
    end
    wait_results(LATENCY + 4);
  endtask

  task automatic bubble_pattern();
    integer r1;
    integer r2;
    integer r3;
    cur_test = "bubbles";
    for (int i = 0; i < BUBBLE_N; i++) begin
      r1 = $random(seed);
      r2 = $random(seed);
      r3 = $random(seed);
      drive(r3[1:0] != 2'b00, r1[OPERAND_W-1:0], r2[OPERAND_W-1:0]);  // about one gap in four
    end
    wait_results(LATENCY + 4);
  endtask

  initial begin
    in_valid        = 1'b1;  // valid held high through reset
    a               = '1;
    b               = '1;
    seed            = 9;
    cur_test        = "reset";
    head_prod       = '0;
    head_name       = "none";
    pending         = 0;
    valid_hist      = '0;
    value_errors    = 0;
    protocol_errors = 0;
    wait (rst == 1'b0);
    in_valid = 1'b0;
    a        = '0;
    b        = '0;
    repeat (2) drive(1'b0, '0, '0);
    corner_products();
    random_stream();
    bubble_pattern();
    cur_test = "idle";
    repeat (LATENCY + 2) drive(1'b0, '0, '0);
    $display("checks done: %0d value errors, %0d protocol errors",
             value_errors, protocol_errors);
    if (value_errors + protocol_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("simulation timed out after %0d ns in test %s", WATCHDOG_NS, cur_test);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: wallace_mult_24x24.f
hw/wallace_pkg.sv
hw/csa_layer.sv
hw/partial_product_stage.sv
hw/reduction_stage.sv
hw/low_byte_resolver.sv
hw/wallace_mult_24x24.sv
verification/tb_clock.sv
verification/tb_wallace_mult_24x24.sv

// File: run.sh
#!/bin/sh
# build and run the multiplier testbench with verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module tb_wallace_mult_24x24 \
  -f wallace_mult_24x24.f \
  -o sim_wallace \
  && ./obj_dir/sim_wallace > sim.log 2>&1 \
  || { echo "build or simulation failed"; exit 1; }

cat sim.log

grep -q "^NO ERRORS$" sim.log \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL"; exit 1; }
